/* design/imuldiv_pkg.sv */
//--------------------------------------------------------------------
// shared definitions for the multiply/divide unit
// RTL files refer to these by scoped name, no import
//--------------------------------------------------------------------

`default_nettype none

package imuldiv_pkg;

  //--------------------------------------------------------------------
  // function codes
  //--------------------------------------------------------------------

  // fn_mul  : signed multiply, full product
  // fn_div  : signed divide, {remainder, quotient}
  // fn_divu : unsigned divide, same layout
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_e;

  //--------------------------------------------------------------------
  // message widths
  //--------------------------------------------------------------------

  // operand width, default for the data_width module parameter
  localparam int data_width = 32;

  // response payload carries two operand-sized halves
  localparam int result_width = 2 * data_width;

  //--------------------------------------------------------------------
  // iteration counts at the default width
  //--------------------------------------------------------------------

  // one quotient bit per step
  localparam int div_steps = data_width;

  // one multiplier bit per step
  localparam int mul_steps = data_width;

endpackage

`default_nettype wire

/* design/int_div_ctrl.sv */
//--------------------------------------------------------------------
// divider control FSM: idle, calc, done with a step counter
// drives the datapath enables and the valid/ready handshake
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module int_div_ctrl #(
  parameter int data_width = imuldiv_pkg::data_width
) (
  input  logic clk,
  input  logic reset,
  input  logic div_req_val,
  input  logic div_resp_rdy,
  input  logic sub_neg,
  output logic div_req_rdy,
  output logic div_resp_val,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic sub_mux_sel,
  output logic result_en
);

  // step count scales with the operand width
  localparam int steps = imuldiv_pkg::div_steps * data_width / imuldiv_pkg::data_width;
  // counter also has to hold the final result cycle
  localparam int cnt_w = $clog2(steps + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e           state;
  logic [cnt_w-1:0] count;
  logic             req_go;
  logic             resp_go;
  logic             last_step;

  assign req_go    = div_req_val && div_req_rdy;
  assign resp_go   = div_resp_val && div_resp_rdy;
  assign last_step = (count == cnt_w'(steps));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          // count runs past the steps by one for the result cycle
          if (last_step) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          // hold the result until it is taken
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_comb begin
    div_req_rdy  = 1'b0;
    div_resp_val = 1'b0;
    a_en         = 1'b0;
    b_en         = 1'b0;
    a_mux_sel    = 1'b0;
    sub_mux_sel  = sub_neg;
    result_en    = 1'b0;
    case (state)
      st_idle: begin
        div_req_rdy = 1'b1;
        // load operands on the transfer
        a_en        = req_go;
        b_en        = req_go;
      end
      st_calc: begin
        a_mux_sel = 1'b1;
        a_en      = !last_step;
        result_en = last_step;
      end
      st_done: begin
        div_resp_val = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* design/int_div_dpath.sv */
//--------------------------------------------------------------------
// divider datapath: restoring shift-subtract on a 2w+1 bit register
// driven by int_div_ctrl through enables and mux selects
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module int_div_dpath #(
  parameter int data_width = imuldiv_pkg::data_width
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    div_req_signed,
  input  logic [data_width-1:0]   div_req_a,
  input  logic [data_width-1:0]   div_req_b,
  input  logic                    a_en,
  input  logic                    b_en,
  input  logic                    a_mux_sel,
  input  logic                    sub_mux_sel,
  input  logic                    result_en,
  output logic [2*data_width-1:0] div_resp_result,
  output logic                    sub_neg
);

  // working register width, remainder on top, quotient below
  localparam int ww = 2 * data_width + 1;

  //--------------------------------------------------------------------
  // operand load and sign removal
  //--------------------------------------------------------------------

  logic                  sign_a_in;
  logic                  sign_b_in;
  logic [data_width-1:0] mag_a;
  logic [data_width-1:0] mag_b;

  // sign bits only count for signed divide
  assign sign_a_in = div_req_signed && div_req_a[data_width-1];
  assign sign_b_in = div_req_signed && div_req_b[data_width-1];

  // magnitudes, the minimum value maps onto itself as unsigned
  assign mag_a = sign_a_in ? -div_req_a : div_req_a;
  assign mag_b = sign_b_in ? -div_req_b : div_req_b;

  logic [data_width-1:0] b_reg;
  logic                  sign_a_reg;
  logic                  sign_b_reg;
  logic                  b_zero;

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
      b_zero     <= 1'b0;
    end else if (b_en) begin
      sign_a_reg <= sign_a_in;
      sign_b_reg <= sign_b_in;
      b_zero     <= (div_req_b == '0);
    end
  end

  // divisor magnitude
  always_ff @(posedge clk) begin
    if (b_en) begin
      b_reg <= mag_b;
    end
  end

  //--------------------------------------------------------------------
  // shift-subtract step
  //--------------------------------------------------------------------

  logic [ww-1:0] a_reg;
  logic [ww-1:0] a_shift;
  logic [ww-1:0] divisor;
  logic [ww-1:0] sub_out;
  logic [ww-1:0] sub_mux_out;
  logic [ww-1:0] a_mux_out;

  assign a_shift = {a_reg[ww-2:0], 1'b0};

  // divisor lined up with the remainder half
  assign divisor = {1'b0, b_reg, {data_width{1'b0}}};
  assign sub_out = a_shift - divisor;

  // top bit set means the partial remainder is smaller than the divisor
  assign sub_neg = sub_out[ww-1];

  // keep the shifted value, or take the difference with quotient bit one
  assign sub_mux_out = sub_mux_sel ? a_shift : {sub_out[ww-1:1], 1'b1};

  // first load puts the dividend magnitude in the quotient half
  assign a_mux_out = a_mux_sel ? sub_mux_out
                               : {{(data_width + 1){1'b0}}, mag_a};

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
  end

  //--------------------------------------------------------------------
  // result sign repair
  //--------------------------------------------------------------------

  logic [data_width-1:0] quot;
  logic [data_width-1:0] rem;
  logic [data_width-1:0] fix_quot;
  logic [data_width-1:0] fix_rem;

  assign quot = a_reg[data_width-1:0];
  assign rem  = a_reg[2*data_width-1:data_width];

  // divide by zero forces all ones, otherwise negate when signs differ
  assign fix_quot = b_zero                    ? '1    :
                    (sign_a_reg ^ sign_b_reg) ? -quot : quot;

  // remainder follows the dividend, so x/0 gives back x
  assign fix_rem = sign_a_reg ? -rem : rem;

  always_ff @(posedge clk) begin
    if (result_en) begin
      div_resp_result <= {fix_rem, fix_quot};
    end
  end

endmodule

`default_nettype wire

/* design/int_div_iterative.sv */
//--------------------------------------------------------------------
// iterative divider, joins int_div_dpath and int_div_ctrl
// one request at a time, result is {remainder, quotient}
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module int_div_iterative #(
  parameter int data_width = imuldiv_pkg::data_width
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    div_req_signed,
  input  logic [data_width-1:0]   div_req_a,
  input  logic [data_width-1:0]   div_req_b,
  input  logic                    div_req_val,
  output logic                    div_req_rdy,
  output logic [2*data_width-1:0] div_resp_result,
  output logic                    div_resp_val,
  input  logic                    div_resp_rdy
);

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;
  logic result_en;
  // datapath to control
  logic sub_neg;

  int_div_dpath #(
    .data_width (data_width)
  ) dpath (
    .clk             (clk),
    .reset           (reset),
    .div_req_signed  (div_req_signed),
    .div_req_a       (div_req_a),
    .div_req_b       (div_req_b),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .sub_mux_sel     (sub_mux_sel),
    .result_en       (result_en),
    .div_resp_result (div_resp_result),
    .sub_neg         (sub_neg)
  );

  int_div_ctrl #(
    .data_width (data_width)
  ) ctrl (
    .clk          (clk),
    .reset        (reset),
    .div_req_val  (div_req_val),
    .div_resp_rdy (div_resp_rdy),
    .sub_neg      (sub_neg),
    .div_req_rdy  (div_req_rdy),
    .div_resp_val (div_resp_val),
    .a_en         (a_en),
    .b_en         (b_en),
    .a_mux_sel    (a_mux_sel),
    .sub_mux_sel  (sub_mux_sel),
    .result_en    (result_en)
  );

endmodule

`default_nettype wire

/* design/int_mul_iterative.sv */
//--------------------------------------------------------------------
// iterative shift-add signed multiplier, full 2w bit product
// same idle/calc/done handshake timing as the divider
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module int_mul_iterative #(
  parameter int data_width = imuldiv_pkg::data_width
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [data_width-1:0]   mul_req_a,
  input  logic [data_width-1:0]   mul_req_b,
  input  logic                    mul_req_val,
  output logic                    mul_req_rdy,
  output logic [2*data_width-1:0] mul_resp_result,
  output logic                    mul_resp_val,
  input  logic                    mul_resp_rdy
);

  // step count scales with the operand width
  localparam int steps = imuldiv_pkg::mul_steps * data_width / imuldiv_pkg::data_width;
  localparam int cnt_w = $clog2(steps + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  //--------------------------------------------------------------------
  // control
  //--------------------------------------------------------------------

  state_e           state;
  logic [cnt_w-1:0] count;
  logic             req_go;
  logic             resp_go;
  logic             last_step;

  assign mul_req_rdy  = (state == st_idle);
  assign mul_resp_val = (state == st_done);
  assign req_go       = mul_req_val && mul_req_rdy;
  assign resp_go      = mul_resp_val && mul_resp_rdy;
  assign last_step    = (count == cnt_w'(steps));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (last_step) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // datapath
  //--------------------------------------------------------------------

  logic                    sign_a;
  logic                    sign_b;
  logic [data_width-1:0]   mag_a;
  logic [data_width-1:0]   mag_b;
  logic [2*data_width-1:0] mcand;
  logic [data_width-1:0]   mplier;
  logic [2*data_width-1:0] acc;
  logic                    neg;

  assign sign_a = mul_req_a[data_width-1];
  assign sign_b = mul_req_b[data_width-1];
  assign mag_a  = sign_a ? -mul_req_a : mul_req_a;
  assign mag_b  = sign_b ? -mul_req_b : mul_req_b;

  always_ff @(posedge clk) begin
    if (req_go) begin
      mcand  <= {{data_width{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
      neg    <= sign_a ^ sign_b;
    end else if (state == st_calc && !last_step) begin
      // add the multiplicand for a set multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= {mcand[2*data_width-2:0], 1'b0};
      mplier <= {1'b0, mplier[data_width-1:1]};
    end
  end

  // sign repair in the cycle after the last step
  always_ff @(posedge clk) begin
    if (state == st_calc && last_step) begin
      mul_resp_result <= neg ? -acc : acc;
    end
  end

endmodule

`default_nettype wire

/* design/int_muldiv_unit.sv */
//--------------------------------------------------------------------
// multiply/divide top level, steers requests to the free unit
// a two-entry order queue returns responses in request order
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module int_muldiv_unit #(
  parameter  int data_width = imuldiv_pkg::data_width,
  localparam int resp_width = imuldiv_pkg::result_width * data_width / imuldiv_pkg::data_width
) (
  input  logic                   clk,
  input  logic                   reset,
  input  imuldiv_pkg::muldiv_fn_e req_fn,
  input  logic [data_width-1:0]  req_a,
  input  logic [data_width-1:0]  req_b,
  input  logic                   req_val,
  output logic                   req_rdy,
  output logic [resp_width-1:0]  resp_result,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  //--------------------------------------------------------------------
  // request steering
  //--------------------------------------------------------------------

  logic                  is_div;
  logic                  div_req_signed;
  logic                  div_req_val;
  logic                  div_req_rdy;
  logic [resp_width-1:0] div_resp_result;
  logic                  div_resp_val;
  logic                  div_resp_rdy;
  logic                  mul_req_val;
  logic                  mul_req_rdy;
  logic [resp_width-1:0] mul_resp_result;
  logic                  mul_resp_val;
  logic                  mul_resp_rdy;

  // order queue state, unit id 1 means divider
  logic [1:0] q_id;
  logic       q_head;
  logic [1:0] q_count;
  logic       q_full;
  logic       head_div;
  logic       push;
  logic       pop;

  assign is_div         = (req_fn != imuldiv_pkg::fn_mul);
  assign div_req_signed = (req_fn == imuldiv_pkg::fn_div);
  assign q_full         = (q_count == 2'd2);

  // a unit only sees the request while there is room to track it
  assign div_req_val = req_val && is_div && !q_full;
  assign mul_req_val = req_val && !is_div && !q_full;
  assign req_rdy     = (is_div ? div_req_rdy : mul_req_rdy) && !q_full;

  //--------------------------------------------------------------------
  // order queue
  //--------------------------------------------------------------------

  assign push     = req_val && req_rdy;
  assign pop      = resp_val && resp_rdy;
  assign head_div = (q_count != 2'd0) && q_id[q_head];

  always_ff @(posedge clk) begin
    if (reset) begin
      q_head  <= 1'b0;
      q_count <= 2'd0;
    end else begin
      if (pop) begin
        q_head <= ~q_head;
      end
      q_count <= q_count + 2'(push) - 2'(pop);
    end
  end

  // tail slot sits one past the head when an entry is waiting
  always_ff @(posedge clk) begin
    if (push) begin
      q_id[q_head ^ q_count[0]] <= is_div;
    end
  end

  //--------------------------------------------------------------------
  // response merge, only the head unit sees resp_rdy
  //--------------------------------------------------------------------

  assign resp_val     = (q_count != 2'd0) && (head_div ? div_resp_val : mul_resp_val);
  assign resp_result  = head_div ? div_resp_result : mul_resp_result;
  assign div_resp_rdy = resp_rdy && (q_count != 2'd0) && head_div;
  assign mul_resp_rdy = resp_rdy && (q_count != 2'd0) && !head_div;

  int_div_iterative #(
    .data_width (data_width)
  ) div_unit (
    .clk             (clk),
    .reset           (reset),
    .div_req_signed  (div_req_signed),
    .div_req_a       (req_a),
    .div_req_b       (req_b),
    .div_req_val     (div_req_val),
    .div_req_rdy     (div_req_rdy),
    .div_resp_result (div_resp_result),
    .div_resp_val    (div_resp_val),
    .div_resp_rdy    (div_resp_rdy)
  );

  int_mul_iterative #(
    .data_width (data_width)
  ) mul_unit (
    .clk             (clk),
    .reset           (reset),
    .mul_req_a       (req_a),
    .mul_req_b       (req_b),
    .mul_req_val     (mul_req_val),
    .mul_req_rdy     (mul_req_rdy),
    .mul_resp_result (mul_resp_result),
    .mul_resp_val    (mul_resp_val),
    .mul_resp_rdy    (mul_resp_rdy)
  );

endmodule

`default_nettype wire

/* verification/int_muldiv_properties.sv */
//--------------------------------------------------------------------
// handshake checks on the multiply/divide top level
// bound into int_muldiv_unit from the testbench
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module int_muldiv_properties #(
  parameter int data_width = imuldiv_pkg::data_width
) (
  input logic                    clk,
  input logic                    reset,
  input logic [1:0]              req_fn,
  input logic [data_width-1:0]   req_a,
  input logic [data_width-1:0]   req_b,
  input logic                    req_val,
  input logic                    req_rdy,
  input logic [2*data_width-1:0] resp_result,
  input logic                    resp_val,
  input logic                    resp_rdy,
  input logic [1:0]              q_count,
  input logic                    div_resp_val,
  input logic                    mul_resp_val
);

  // count of failed checks
  int failures = 0;

  // request waits with its payload until accepted
  req_hold: assert property (@(posedge clk) disable iff (reset)
    req_val && !req_rdy |=> req_val && $stable(req_fn) && $stable(req_a) && $stable(req_b))
    else begin
      $error("request dropped or changed before its transfer");
      failures++;
    end

  // finished result stays put under back-pressure
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else begin
      $error("response dropped or changed before its transfer");
      failures++;
    end

  resp_reset: assert property (@(posedge clk) reset |=> !resp_val)
    else begin
      $error("resp_val high right after reset");
      failures++;
    end

  // neither unit may finish while the order queue tracks nothing
  resp_orphan: assert property (@(posedge clk) disable iff (reset)
    (q_count == 2'd0) |-> !div_resp_val && !mul_resp_val)
    else begin
      $error("a unit finished with the order queue empty");
      failures++;
    end

endmodule

`default_nettype wire

/* verification/int_muldiv_tb.sv */
//--------------------------------------------------------------------
// testbench for int_muldiv_unit with directed and random requests,
// reference model, in-order response checking and back-pressure
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module int_muldiv_tb;

  localparam int data_width = imuldiv_pkg::data_width;
  localparam int rw         = 2 * data_width;

  // request counts per test size the watchdog
  localparam int n_directed     = 16 + 7 + 7;
  localparam int n_mul_rand     = 40;
  localparam int n_mix          = 60;
  localparam int n_bp           = 60;
  localparam int n_total        = n_directed + n_mul_rand + n_mix + n_bp;
  localparam int timeout_cycles = n_total * (2 * data_width + 4) + 500;

  logic                    clk;
  logic                    reset;
  imuldiv_pkg::muldiv_fn_e req_fn;
  logic [data_width-1:0]   req_a;
  logic [data_width-1:0]   req_b;
  logic                    req_val;
  logic                    req_rdy;
  logic [rw-1:0]           resp_result;
  logic                    resp_val;
  logic                    resp_rdy;

  integer        seed;
  integer        bp_seed;
  logic [31:0]   bp_rnd;
  logic          bp_mode;
  logic [rw-1:0] exp_q[$];
  logic [rw-1:0] expected_value;
  int            req_count      = 0;
  int            resp_count     = 0;
  int            errors         = 0;
  int            overlap_cycles = 0;
  int            req_start      = 0;
  int            err_start      = 0;

  int_muldiv_unit #(
    .data_width (data_width)
  ) UUT (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  bind int_muldiv_unit int_muldiv_properties #(
    .data_width (data_width)
  ) props (
    .clk          (clk),
    .reset        (reset),
    .req_fn       (req_fn),
    .req_a        (req_a),
    .req_b        (req_b),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_result  (resp_result),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .q_count      (q_count),
    .div_resp_val (div_resp_val),
    .mul_resp_val (mul_resp_val)
  );

  //--------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------

  // mul gives the full signed product and divides give {remainder, quotient}
  function automatic logic [rw-1:0] expected_result(input imuldiv_pkg::muldiv_fn_e fn,
                                                    input logic [data_width-1:0] a,
                                                    input logic [data_width-1:0] b);
    longint sa;
    longint sb;
    longint q;
    longint r;
    sa = {{data_width{a[data_width-1]}}, a};
    sb = {{data_width{b[data_width-1]}}, b};
    if (fn == imuldiv_pkg::fn_mul) begin
      return sa * sb;
    end
    // x/0 gives all ones and hands back the dividend
    if (b == '0) begin
      return {a, {data_width{1'b1}}};
    end
    if (fn == imuldiv_pkg::fn_divu) begin
      return {a % b, a / b};
    end
    // signed overflow case wraps to the minimum
    if (a == {1'b1, {(data_width - 1){1'b0}}} && b == '1) begin
      return {{data_width{1'b0}}, a};
    end
    // truncating division with the remainder taking the dividend's sign
    q = sa / sb;
    r = sa % sb;
    return {r[data_width-1:0], q[data_width-1:0]};
  endfunction

  //--------------------------------------------------------------------
  // clock, back-pressure, watchdog
  //--------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // resp_rdy has its own random stream so stimulus draws stay fixed
  initial begin
    resp_rdy = 1'b0;
    bp_seed  = 32'hb0c5;
    forever begin
      @(negedge clk);
      if (bp_mode) begin
        bp_rnd   = $random(bp_seed);
        resp_rdy = bp_rnd[0];
      end else begin
        resp_rdy = !reset;
      end
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: %0d of %0d requests answered after %0d cycles",
             resp_count, req_count, timeout_cycles);
    $display("Regression failed");
    $finish;
  end

  // two entries in flight means a second unit was started
  always @(negedge clk) begin
    if (exp_q.size() == 2) begin
      overlap_cycles++;
    end
  end

  //--------------------------------------------------------------------
  // response checking
  //--------------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      resp_count++;
      assert (exp_q.size() != 0) else begin
        $display("response at %0t arrived with no request outstanding", $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        expected_value = exp_q.pop_front();
        assert (resp_result === expected_value) else begin
          $display("ERROR at %0t: resp_result expected %h got %h",
                   $time, expected_value, resp_result);
          errors++;
        end
      end
    end
  end

  //--------------------------------------------------------------------
  // stimulus tasks
  //--------------------------------------------------------------------

  // hold the request until the posedge where req_rdy is seen high
  task automatic send_request(input imuldiv_pkg::muldiv_fn_e fn,
                              input logic [data_width-1:0] a,
                              input logic [data_width-1:0] b);
    @(negedge clk);
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    exp_q.push_back(expected_result(fn, a, b));
    req_count++;
  endtask

  task automatic divide_both(input logic [data_width-1:0] a, input logic [data_width-1:0] b);
    send_request(imuldiv_pkg::fn_div, a, b);
    send_request(imuldiv_pkg::fn_divu, a, b);
  endtask

  // divisor shifted down by a random amount to spread its size
  task automatic random_request;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    int                    sel;
    a   = $random(seed);
    b   = $random(seed);
    b   = b >> ({$random(seed)} % data_width);
    sel = {$random(seed)} % 3;
    case (sel)
      0:       send_request(imuldiv_pkg::fn_mul, a, b);
      1:       send_request(imuldiv_pkg::fn_div, a, b);
      default: send_request(imuldiv_pkg::fn_divu, a, b);
    endcase
  endtask

  task automatic start_test;
    req_start = req_count;
    err_start = errors;
  endtask

  // drop req_val, wait for every response, then report
  task automatic finish_test(input string name);
    @(negedge clk);
    req_val = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    $display("test %s done with %0d requests, %0d errors", name,
             req_count - req_start, errors - err_start);
  endtask

  //--------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------

  initial begin
    reset   = 1'b1;
    req_fn  = imuldiv_pkg::fn_mul;
    req_a   = '0;
    req_b   = '0;
    req_val = 1'b0;
    bp_mode = 1'b0;
    seed    = 32'hb0c5;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // sign combinations, top bit set, largest values
    start_test();
    divide_both(32'd7, 32'd2);
    divide_both(32'hffff_fff9, 32'd2);
    divide_both(32'd7, 32'hffff_fffe);
    divide_both(32'hffff_fff9, 32'hffff_fffe);
    divide_both(32'h8000_0005, 32'd3);
    divide_both(32'hffff_ffff, 32'h10);
    divide_both(32'h7fff_ffff, 32'h7fff_ffff);
    divide_both(32'hffff_ffff, 32'hffff_ffff);
    finish_test("div_corner");

    start_test();
    send_request(imuldiv_pkg::fn_div, 32'd5, 32'd0);
    send_request(imuldiv_pkg::fn_div, 32'hffff_fffb, 32'd0);
    send_request(imuldiv_pkg::fn_divu, 32'd5, 32'd0);
    send_request(imuldiv_pkg::fn_divu, 32'hffff_ffff, 32'd0);
    send_request(imuldiv_pkg::fn_div, 32'd0, 32'd0);
    send_request(imuldiv_pkg::fn_div, 32'h8000_0000, 32'hffff_ffff);
    send_request(imuldiv_pkg::fn_divu, 32'h8000_0000, 32'hffff_ffff);
    finish_test("div_special");

    start_test();
    send_request(imuldiv_pkg::fn_mul, 32'd0, 32'd0);
    send_request(imuldiv_pkg::fn_mul, 32'd1, 32'hffff_ffff);
    send_request(imuldiv_pkg::fn_mul, 32'hffff_ffff, 32'hffff_ffff);
    send_request(imuldiv_pkg::fn_mul, 32'h8000_0000, 32'h8000_0000);
    send_request(imuldiv_pkg::fn_mul, 32'h7fff_ffff, 32'h7fff_ffff);
    send_request(imuldiv_pkg::fn_mul, 32'h8000_0000, 32'h7fff_ffff);
    send_request(imuldiv_pkg::fn_mul, 32'd123456, 32'hffff_e12e);
    for (int i = 0; i < n_mul_rand; i++) begin
      send_request(imuldiv_pkg::fn_mul, $random(seed), $random(seed));
    end
    finish_test("mul");

    // back to back, so a multiply and a divide run together
    start_test();
    overlap_cycles = 0;
    for (int i = 0; i < n_mix; i++) begin
      random_request();
    end
    finish_test("mixed");
    assert (overlap_cycles > 0) else begin
      $display("no multiply and divide were ever in flight together");
      errors++;
    end

    start_test();
    bp_mode = 1'b1;
    for (int i = 0; i < n_bp; i++) begin
      random_request();
    end
    finish_test("backpressure");
    bp_mode = 1'b0;

    // a result left valid after its transfer gets taken again here
    repeat (4) @(negedge clk);

    // a duplicated response would show up as an extra count
    assert (resp_count == req_count) else begin
      $display("%0d requests were sent but %0d responses came back", req_count, resp_count);
      errors++;
    end
    $display("summary: %0d requests, %0d responses, %0d errors, %0d assertion failures",
             req_count, resp_count, errors, UUT.props.failures);
    if (errors == 0 && UUT.props.failures == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
design/imuldiv_pkg.sv
design/int_div_dpath.sv
design/int_div_ctrl.sv
design/int_div_iterative.sv
design/int_mul_iterative.sv
design/int_muldiv_unit.sv
verification/int_muldiv_properties.sv
verification/int_muldiv_tb.sv
